/* verilog/sens_io_defs.svh */
// Register map and bit positions of the sensor I/O command registers.
// Each level bit has its enable bit directly above it (level + 1);
// two-bit GP mode fields have the enable two bits above the field base.
// PXD_CLK_DIV must be even and PXD_CLK_DIV/2 - 1 must fit the counter.
// Values are fixed by the sensor board and are not module parameters.
`ifndef SENS_IO_DEFS_SVH
`define SENS_IO_DEFS_SVH

// command port
`define SENSIO_ADDR_BITS    3   // register address width
`define SENSIO_DATA_BITS    32  // write data width

// register addresses
`define SENSIO_CTRL         0   // sensor control pins, pll reset, gp modes
`define SENSIO_JTAG         2   // bit-banged jtag to external fpga
`define SENSIO_SKIP         3   // lines to skip after sof

// control register, level bits (enable at +1)
`define SENS_CTRL_MRST      0   // master reset, pin active low
`define SENS_CTRL_ARST      2   // analog reset
`define SENS_CTRL_ARO       4   // software aro level
`define SENS_CTRL_RST_MMCM  6   // pll reset, only stretches prsts

// control register, gp mode fields (enable at +2)
`define SENS_CTRL_GP0       12  // bits 13:12, enable 14
`define SENS_CTRL_GP1       15  // bits 16:15, enable 17
`define SENS_GP_MODE_BITS   2   // float / low / high / trigger

// jtag register, level bits (enable at +1)
`define SENS_JTAG_TDI       0
`define SENS_JTAG_TMS       2
`define SENS_JTAG_TCK       4
`define SENS_JTAG_PGMEN     8   // switches pins to jtag

// line skipper
`define SENSIO_SKIP_BITS    8   // skip count width

// sensor clock divider
`define PXD_CLK_DIV         10  // pclk cycles per sensor clock
`define PXD_CLK_DIV_BITS    4   // divider counter width

`endif

/* verilog/sens_io_pkg.sv */
// Types shared by the sensor I/O blocks.
// Widths come from sens_io_defs.svh, which must be on the include path.
`default_nettype none

`include "sens_io_defs.svh"

package sens_io_pkg;

    typedef logic [`SENSIO_ADDR_BITS-1:0] cmd_addr_t;    // register address
    typedef logic [`SENSIO_DATA_BITS-1:0] cmd_data_t;    // write data word
    typedef logic [`SENSIO_SKIP_BITS-1:0] skip_cnt_t;    // lines to skip
    typedef logic [`PXD_CLK_DIV_BITS-1:0] clk_div_cnt_t; // sensor clock divider

    // GP pin mode, encoding matches the control register field
    typedef enum logic [`SENS_GP_MODE_BITS-1:0] {
        GP_FLOAT = 2'd0, // output disabled
        GP_LOW   = 2'd1, // driven low
        GP_HIGH  = 2'd2, // driven high
        GP_TRIG  = 2'd3  // follows aro
    } gp_mode_e;

endpackage

`default_nettype wire

/* verilog/sens_io_regs.sv */
// Command registers of the sensor I/O block.
// A write is a single-cycle strobe with address and data; no handshake.
// Word and set strobe are registered first, fields update one edge later.
// A field changes only when its enable bit is set in the written word.
// prsts_o is held while reset, sensor mrst (low) or pll reset is active
// and released two cycles after all of them clear.
`default_nettype none

`include "sens_io_defs.svh"

module sens_io_regs
    import sens_io_pkg::*;
(
    input  logic      pclk,
    input  logic      async_prst_with_sens_mrst,
    input  logic      cmd_we_i,
    input  cmd_addr_t cmd_addr_i,
    input  cmd_data_t cmd_data_i,
    output logic      sens_mrst_n_o,  // sensor mrst level, low = in reset
    output logic      sens_arst_o,
    output logic      aro_soft_o,
    output gp_mode_e  gp0_mode_o,
    output gp_mode_e  gp1_mode_o,
    output logic      pgmen_o,        // jtag mode
    output logic      jtag_tck_o,
    output logic      jtag_tms_o,
    output logic      jtag_tdi_o,
    output skip_cnt_t lines_skip_o,
    output logic      prsts_o         // pixel domain reset
);

    cmd_data_t  data_r;      // captured write word
    logic       set_ctrl_r;  // per-address set strobes
    logic       set_jtag_r;
    logic       set_skip_r;
    logic       rst_mmcm;    // pll reset bit
    logic [1:0] prst_sr;     // reset stretcher

    always_ff @(posedge pclk) begin
        if (cmd_we_i) data_r <= cmd_data_i;
    end

    always_ff @(posedge pclk or posedge async_prst_with_sens_mrst) begin
        if (async_prst_with_sens_mrst) begin
            set_ctrl_r <= 1'b0;
            set_jtag_r <= 1'b0;
            set_skip_r <= 1'b0;
        end else begin
            set_ctrl_r <= cmd_we_i && (cmd_addr_i == cmd_addr_t'(`SENSIO_CTRL));
            set_jtag_r <= cmd_we_i && (cmd_addr_i == cmd_addr_t'(`SENSIO_JTAG));
            set_skip_r <= cmd_we_i && (cmd_addr_i == cmd_addr_t'(`SENSIO_SKIP));
        end
    end

    // control register fields
    always_ff @(posedge pclk or posedge async_prst_with_sens_mrst) begin
        if (async_prst_with_sens_mrst) begin
            sens_mrst_n_o <= 1'b0; // sensor held in reset
            sens_arst_o   <= 1'b0;
            aro_soft_o    <= 1'b0;
            rst_mmcm      <= 1'b0;
            gp0_mode_o    <= GP_FLOAT;
            gp1_mode_o    <= GP_FLOAT;
        end else if (set_ctrl_r) begin
            if (data_r[`SENS_CTRL_MRST + 1])     sens_mrst_n_o <= data_r[`SENS_CTRL_MRST];
            if (data_r[`SENS_CTRL_ARST + 1])     sens_arst_o   <= data_r[`SENS_CTRL_ARST];
            if (data_r[`SENS_CTRL_ARO + 1])      aro_soft_o    <= data_r[`SENS_CTRL_ARO]; // own enable
            if (data_r[`SENS_CTRL_RST_MMCM + 1]) rst_mmcm      <= data_r[`SENS_CTRL_RST_MMCM];
            if (data_r[`SENS_CTRL_GP0 + 2])
                gp0_mode_o <= gp_mode_e'(data_r[`SENS_CTRL_GP0 +: `SENS_GP_MODE_BITS]);
            if (data_r[`SENS_CTRL_GP1 + 2])
                gp1_mode_o <= gp_mode_e'(data_r[`SENS_CTRL_GP1 +: `SENS_GP_MODE_BITS]);
        end
    end

    // jtag register fields
    always_ff @(posedge pclk or posedge async_prst_with_sens_mrst) begin
        if (async_prst_with_sens_mrst) begin
            pgmen_o    <= 1'b0;
            jtag_tck_o <= 1'b0;
            jtag_tms_o <= 1'b0;
            jtag_tdi_o <= 1'b0;
        end else if (set_jtag_r) begin
            if (data_r[`SENS_JTAG_PGMEN + 1]) pgmen_o    <= data_r[`SENS_JTAG_PGMEN];
            if (data_r[`SENS_JTAG_TCK + 1])   jtag_tck_o <= data_r[`SENS_JTAG_TCK];
            if (data_r[`SENS_JTAG_TMS + 1])   jtag_tms_o <= data_r[`SENS_JTAG_TMS];
            if (data_r[`SENS_JTAG_TDI + 1])   jtag_tdi_o <= data_r[`SENS_JTAG_TDI];
        end
    end

    always_ff @(posedge pclk or posedge async_prst_with_sens_mrst) begin
        if (async_prst_with_sens_mrst) lines_skip_o <= '0;
        else if (set_skip_r)           lines_skip_o <= data_r[`SENSIO_SKIP_BITS-1:0]; // no enable bit
    end

    // pixel reset stretcher, shifts out ones once sensor and pll are out of reset
    always_ff @(posedge pclk or posedge async_prst_with_sens_mrst) begin
        if (async_prst_with_sens_mrst)   prst_sr <= 2'b11;
        else if (!sens_mrst_n_o || rst_mmcm) prst_sr <= 2'b11;
        else                             prst_sr <= {1'b0, prst_sr[1]};
    end

    assign prsts_o = prst_sr[0];

endmodule

`default_nettype wire

/* verilog/sens_pin_mux.sv */
// Sensor control pin selection, purely combinational.
// In jtag mode TCK/TMS/TDI take over the ARO, ARST and GP0 pins.
// Tri-state pins come out as a value plus an output enable.
`default_nettype none

module sens_pin_mux
    import sens_io_pkg::*;
(
    input  logic     sens_mrst_n_i,
    input  logic     sens_arst_i,
    input  logic     aro_soft_i,
    input  gp_mode_e gp0_mode_i,
    input  gp_mode_e gp1_mode_i,
    input  logic     pgmen_i,
    input  logic     jtag_tck_i,
    input  logic     jtag_tms_i,
    input  logic     jtag_tdi_i,
    input  logic     trigger_mode_i, // 1 = triggered, 0 = free running
    input  logic     trig_i,
    output logic     sns_mrst_o,
    output logic     sns_arst_tms_o,
    output logic     sns_ctl_tck_o,
    output logic     sns_gp0_tdi_o,
    output logic     sns_gp0_oe_o,
    output logic     sns_gp1_o,
    output logic     sns_gp1_oe_o
);

    logic aro; // effective aro level

    // gp pin value for a given mode
    function automatic logic gp_level(input gp_mode_e mode, input logic aro_lvl);
        case (mode)
            GP_HIGH: gp_level = 1'b1;
            GP_TRIG: gp_level = aro_lvl;
            default: gp_level = 1'b0; // float drives 0 behind a disabled buffer
        endcase
    endfunction

    assign aro = trigger_mode_i ? ~trig_i : aro_soft_i; // trigger is active low on aro

    assign sns_mrst_o     = sens_mrst_n_i;
    assign sns_arst_tms_o = pgmen_i ? jtag_tms_i : sens_arst_i;
    assign sns_ctl_tck_o  = pgmen_i ? jtag_tck_i : aro;
    assign sns_gp0_tdi_o  = pgmen_i ? jtag_tdi_i : gp_level(gp0_mode_i, aro);
    assign sns_gp0_oe_o   = pgmen_i || (gp0_mode_i != GP_FLOAT); // tdi always driven
    assign sns_gp1_o      = gp_level(gp1_mode_i, aro);
    assign sns_gp1_oe_o   = (gp1_mode_i != GP_FLOAT);

endmodule

`default_nettype wire

/* verilog/sens_ext_clk_gen.sv */
// Sensor reference clock divided down from pclk, 50 % duty.
// Output is low in reset; first toggle PXD_CLK_DIV/2 cycles after release.
// Clock output is a register, not a clock buffer.
`default_nettype none

`include "sens_io_defs.svh"

module sens_ext_clk_gen
    import sens_io_pkg::*;
(
    input  logic pclk,
    input  logic async_prst_with_sens_mrst,
    output logic ext_clk_o
);

    localparam clk_div_cnt_t HALF_M1 = clk_div_cnt_t'(`PXD_CLK_DIV / 2 - 1); // reload value

    clk_div_cnt_t div_cnt; // half-period down counter

    always_ff @(posedge pclk or posedge async_prst_with_sens_mrst) begin
        if (async_prst_with_sens_mrst) begin
            div_cnt   <= HALF_M1;
            ext_clk_o <= 1'b0;
        end else if (div_cnt == '0) begin
            div_cnt   <= HALF_M1;    // next half period
            ext_clk_o <= ~ext_clk_o;
        end else begin
            div_cnt   <= div_cnt - 1'b1;
        end
    end

endmodule

`default_nettype wire

/* verilog/sens_line_skip.sv */
// Suppresses the first lines_skip lines of hact after each sof.
// Masking starts the cycle after sof and ends the cycle after the
// falling edge of the last skipped line. A zero count disables it.
// lines_skip is expected to stay stable during a frame.
`default_nettype none

`include "sens_io_defs.svh"

module sens_line_skip
    import sens_io_pkg::*;
(
    input  logic      pclk,
    input  logic      async_prst_with_sens_mrst,
    input  skip_cnt_t lines_skip_i,
    input  logic      sof_i,   // one-cycle start of frame
    input  logic      hact_i,  // line active level
    output logic      hact_o
);

    logic      hact_r;    // delayed hact for edge detect
    logic      line_end;  // hact falling edge
    logic      some_skip;
    logic      hact_dis;  // mask active
    skip_cnt_t lines_cntr; // lines left to skip

    assign line_end  = hact_r && !hact_i;
    assign some_skip = |lines_skip_i;

    always_ff @(posedge pclk or posedge async_prst_with_sens_mrst) begin
        if (async_prst_with_sens_mrst) begin
            hact_r     <= 1'b0;
            lines_cntr <= '0;
            hact_dis   <= 1'b0;
        end else begin
            hact_r <= hact_i;
            if (!some_skip)                     lines_cntr <= '0;
            else if (sof_i)                     lines_cntr <= lines_skip_i;
            else if ((|lines_cntr) && line_end) lines_cntr <= lines_cntr - 1'b1;
            if (!some_skip)  hact_dis <= 1'b0;
            else if (sof_i)  hact_dis <= 1'b1;
            else if ((lines_cntr[`SENSIO_SKIP_BITS-1:1] == '0) && line_end)
                hact_dis <= 1'b0; // count 1 or less, last skipped line done
        end
    end

    assign hact_o = hact_i && !hact_dis;

endmodule

`default_nettype wire

/* verilog/sens_io_top.sv */
// Sensor front end control, top level.
// Everything runs on pclk with one asynchronous active-high reset.
// Sensor tri-state pins are split into value and output-enable outputs.
// Register writes reach the pins two cycles after the write strobe.
`default_nettype none

module sens_io_top
    import sens_io_pkg::*;
(
    input  logic      pclk,
    input  logic      async_prst_with_sens_mrst,
    input  logic      cmd_we_i,       // one-cycle write strobe
    input  cmd_addr_t cmd_addr_i,
    input  cmd_data_t cmd_data_i,
    input  logic      sof_i,
    input  logic      hact_i,
    input  logic      trigger_mode_i,
    input  logic      trig_i,
    output logic      sns_mrst_o,     // active low sensor reset
    output logic      sns_arst_tms_o,
    output logic      sns_ctl_tck_o,
    output logic      sns_gp0_tdi_o,
    output logic      sns_gp0_oe_o,
    output logic      sns_gp1_o,
    output logic      sns_gp1_oe_o,
    output logic      ext_clk_o,
    output logic      hact_o,
    output logic      prsts_o
);

    logic      sens_mrst_n;
    logic      sens_arst;
    logic      aro_soft;
    gp_mode_e  gp0_mode;
    gp_mode_e  gp1_mode;
    logic      pgmen;
    logic      jtag_tck;
    logic      jtag_tms;
    logic      jtag_tdi;
    skip_cnt_t lines_skip;

    sens_io_regs u_regs (
        .pclk                      (pclk),
        .async_prst_with_sens_mrst (async_prst_with_sens_mrst),
        .cmd_we_i                  (cmd_we_i),
        .cmd_addr_i                (cmd_addr_i),
        .cmd_data_i                (cmd_data_i),
        .sens_mrst_n_o             (sens_mrst_n),
        .sens_arst_o               (sens_arst),
        .aro_soft_o                (aro_soft),
        .gp0_mode_o                (gp0_mode),
        .gp1_mode_o                (gp1_mode),
        .pgmen_o                   (pgmen),
        .jtag_tck_o                (jtag_tck),
        .jtag_tms_o                (jtag_tms),
        .jtag_tdi_o                (jtag_tdi),
        .lines_skip_o              (lines_skip),
        .prsts_o                   (prsts_o)
    );

    sens_pin_mux u_pin_mux (
        .sens_mrst_n_i  (sens_mrst_n),
        .sens_arst_i    (sens_arst),
        .aro_soft_i     (aro_soft),
        .gp0_mode_i     (gp0_mode),
        .gp1_mode_i     (gp1_mode),
        .pgmen_i        (pgmen),
        .jtag_tck_i     (jtag_tck),
        .jtag_tms_i     (jtag_tms),
        .jtag_tdi_i     (jtag_tdi),
        .trigger_mode_i (trigger_mode_i),
        .trig_i         (trig_i),
        .sns_mrst_o     (sns_mrst_o),
        .sns_arst_tms_o (sns_arst_tms_o),
        .sns_ctl_tck_o  (sns_ctl_tck_o),
        .sns_gp0_tdi_o  (sns_gp0_tdi_o),
        .sns_gp0_oe_o   (sns_gp0_oe_o),
        .sns_gp1_o      (sns_gp1_o),
        .sns_gp1_oe_o   (sns_gp1_oe_o)
    );

    sens_ext_clk_gen u_ext_clk (
        .pclk                      (pclk),
        .async_prst_with_sens_mrst (async_prst_with_sens_mrst),
        .ext_clk_o                 (ext_clk_o)
    );

    sens_line_skip u_line_skip (
        .pclk                      (pclk),
        .async_prst_with_sens_mrst (async_prst_with_sens_mrst),
        .lines_skip_i              (lines_skip),
        .sof_i                     (sof_i),
        .hact_i                    (hact_i),
        .hact_o                    (hact_o)
    );

endmodule

`default_nettype wire

/* verification/sens_io_clkgen.sv */
// Clock and reset source for the sensor I/O testbench.
// pclk period is 40 time units, reset is active high for 16 cycles
// and is released on a falling edge.
`default_nettype none

module sens_io_clkgen (
    output logic pclk_o,
    output logic rst_o
);

    initial begin
        pclk_o = 1'b0;
        forever #20 pclk_o = ~pclk_o; // half period
    end

    initial begin
        rst_o = 1'b1;
        repeat (16) @(posedge pclk_o);
        @(negedge pclk_o);
        rst_o = 1'b0;
    end

endmodule

`default_nettype wire

/* verification/sens_io_checker.sv */
// Concurrent checks on the sensor I/O top-level outputs.
// Bound into sens_io_top; sampled on rising pclk, off during reset.
// fail_cnt counts assertion failures so that the testbench can read them.
`default_nettype none

module sens_io_checker
    import sens_io_pkg::*;
(
    input  logic     pclk,
    input  logic     rst_i,
    input  logic     ext_clk_i,
    input  gp_mode_e gp1_mode_i,   // internal register state
    input  logic     sns_gp1_oe_i,
    input  logic     hact_in_i,    // hact before the line skipper
    input  logic     hact_out_i,   // hact after the line skipper
    input  logic     sns_mrst_i,
    input  logic     prsts_i
);

    int unsigned fail_cnt = 0; // read by the testbench at the end

    // six equal samples in a row would be a level held too long
    a_ext_clk_hold: assert property (@(posedge pclk) disable iff (rst_i)
        !$past(rst_i, 5) |-> ((ext_clk_i != $past(ext_clk_i, 1)) ||
                              (ext_clk_i != $past(ext_clk_i, 2)) ||
                              (ext_clk_i != $past(ext_clk_i, 3)) ||
                              (ext_clk_i != $past(ext_clk_i, 4)) ||
                              (ext_clk_i != $past(ext_clk_i, 5))))
    else begin
        fail_cnt++;
        $error("ext_clk_o held one level for more than 5 cycles");
    end

    a_gp1_float: assert property (@(posedge pclk) disable iff (rst_i)
        (gp1_mode_i == GP_FLOAT) |-> !sns_gp1_oe_i)
    else begin
        fail_cnt++;
        $error("sns_gp1_oe_o is set while gp1 mode is float");
    end

    a_hact_mask: assert property (@(posedge pclk) disable iff (rst_i)
        !hact_in_i |-> !hact_out_i)
    else begin
        fail_cnt++;
        $error("hact_o is high while hact_i is low");
    end

    // prsts follows mrst one cycle late
    a_prsts_mrst: assert property (@(posedge pclk) disable iff (rst_i)
        !sns_mrst_i |=> prsts_i)
    else begin
        fail_cnt++;
        $error("prsts_o is low while the sensor is held in reset");
    end

endmodule

bind sens_io_top sens_io_checker u_checker (
    .pclk         (pclk),
    .rst_i        (async_prst_with_sens_mrst),
    .ext_clk_i    (ext_clk_o),
    .gp1_mode_i   (gp1_mode),
    .sns_gp1_oe_i (sns_gp1_oe_o),
    .hact_in_i    (hact_i),
    .hact_out_i   (hact_o),
    .sns_mrst_i   (sns_mrst_o),
    .prsts_i      (prsts_o)
);

`default_nettype wire

/* verification/sens_io_tb.sv */
// Directed testbench for the sensor I/O control block.
// Inputs change on the falling pclk edge, outputs are checked there too.
// Expected pins come from a model of the register fields that applies
// the set-enable rule; pin fields are visible two cycles after a write.
// Random words come from a Galois LFSR, one step per bit taken.
`default_nettype none

`include "sens_io_defs.svh"

module sens_io_tb
    import sens_io_pkg::*;
();

    localparam int CYC         = 40;
    localparam int N_RAND_WR   = 40;
    localparam int TEST_CYCLES = 16 + 30 + N_RAND_WR * 4 + 17 * 4 + 10 * 4 + 12 + 40 * 5 + 3 * 80;
    localparam int WATCHDOG_T  = 2 * TEST_CYCLES * CYC; // double for margin

    logic      pclk;
    logic      rst;
    logic      cmd_we;
    cmd_addr_t cmd_addr;
    cmd_data_t cmd_data;
    logic      sof;
    logic      hact;
    logic      trigger_mode;
    logic      trig;
    logic      sns_mrst;
    logic      sns_arst_tms;
    logic      sns_ctl_tck;
    logic      sns_gp0_tdi;
    logic      sns_gp0_oe;
    logic      sns_gp1;
    logic      sns_gp1_oe;
    logic      ext_clk;
    logic      hact_out;
    logic      prsts;

    // register model
    logic       m_mrst_n;
    logic       m_arst;
    logic       m_aro;
    logic [1:0] m_gp0;
    logic [1:0] m_gp1;
    logic       m_pgmen;
    logic       m_tck;
    logic       m_tms;
    logic       m_tdi;

    logic [31:0] lfsr;
    logic        hact_exp; // expected hact_o for the last driven hact
    int          n_checks;
    int          n_errors;

    sens_io_clkgen u_clkgen (
        .pclk_o (pclk),
        .rst_o  (rst)
    );

    sens_io_top u_sens_io_top (
        .pclk                      (pclk),
        .async_prst_with_sens_mrst (rst),
        .cmd_we_i                  (cmd_we),
        .cmd_addr_i                (cmd_addr),
        .cmd_data_i                (cmd_data),
        .sof_i                     (sof),
        .hact_i                    (hact),
        .trigger_mode_i            (trigger_mode),
        .trig_i                    (trig),
        .sns_mrst_o                (sns_mrst),
        .sns_arst_tms_o            (sns_arst_tms),
        .sns_ctl_tck_o             (sns_ctl_tck),
        .sns_gp0_tdi_o             (sns_gp0_tdi),
        .sns_gp0_oe_o              (sns_gp0_oe),
        .sns_gp1_o                 (sns_gp1),
        .sns_gp1_oe_o              (sns_gp1_oe),
        .ext_clk_o                 (ext_clk),
        .hact_o                    (hact_out),
        .prsts_o                   (prsts)
    );

    // x^32 + x^22 + x^2 + x + 1, right shifting
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        lfsr_next = {1'b0, s[31:1]} ^ (s[0] ? 32'h8020_0003 : 32'h0);
    endfunction

    task automatic rand_bits(input int nbits, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < nbits; i++) begin
            val  = {val[30:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
    endtask

    // pin level of a driven gp mode
    function automatic logic mode_level(input logic [1:0] mode, input logic aro);
        mode_level = (mode == GP_HIGH) || ((mode == GP_TRIG) && aro);
    endfunction

    task automatic check_bit(input string what, input logic act, input logic exp);
        n_checks++;
        assert (act === exp)
        else begin
            n_errors++;
            $display("ERROR %0t: %s is %b, expected %b", $time, what, act, exp);
        end
    endtask

    task automatic check_int(input string what, input int act, input int exp);
        n_checks++;
        assert (act == exp)
        else begin
            n_errors++;
            $display("ERROR %0t: %s is %0d, expected %0d", $time, what, act, exp);
        end
    endtask

    task automatic update_model(input int addr, input logic [31:0] d);
        if (addr == `SENSIO_CTRL) begin
            if (d[`SENS_CTRL_MRST + 1]) m_mrst_n = d[`SENS_CTRL_MRST];
            if (d[`SENS_CTRL_ARST + 1]) m_arst   = d[`SENS_CTRL_ARST];
            if (d[`SENS_CTRL_ARO + 1])  m_aro    = d[`SENS_CTRL_ARO];
            if (d[`SENS_CTRL_GP0 + 2])  m_gp0    = d[`SENS_CTRL_GP0 +: 2];
            if (d[`SENS_CTRL_GP1 + 2])  m_gp1    = d[`SENS_CTRL_GP1 +: 2];
        end else if (addr == `SENSIO_JTAG) begin
            if (d[`SENS_JTAG_PGMEN + 1]) m_pgmen = d[`SENS_JTAG_PGMEN];
            if (d[`SENS_JTAG_TCK + 1])   m_tck   = d[`SENS_JTAG_TCK];
            if (d[`SENS_JTAG_TMS + 1])   m_tms   = d[`SENS_JTAG_TMS];
            if (d[`SENS_JTAG_TDI + 1])   m_tdi   = d[`SENS_JTAG_TDI];
        end
    endtask

    // one-cycle write strobe, returns on the falling edge after sampling
    task automatic write_reg(input int addr, input logic [31:0] data);
        @(negedge pclk);
        cmd_we   = 1'b1;
        cmd_addr = cmd_addr_t'(addr);
        cmd_data = data;
        @(negedge pclk);
        cmd_we   = 1'b0;
        update_model(addr, data);
    endtask

    task automatic settle();
        @(negedge pclk); // field reaches the pins
    endtask

    task automatic check_pins();
        logic aro;
        logic gp0_oe;
        logic gp1_oe;
        aro    = trigger_mode ? ~trig : m_aro;
        gp0_oe = m_pgmen || (m_gp0 != GP_FLOAT);
        gp1_oe = (m_gp1 != GP_FLOAT);
        check_bit("sns_mrst_o", sns_mrst, m_mrst_n);
        check_bit("sns_arst_tms_o", sns_arst_tms, m_pgmen ? m_tms : m_arst);
        check_bit("sns_ctl_tck_o", sns_ctl_tck, m_pgmen ? m_tck : aro);
        check_bit("sns_gp0_oe_o", sns_gp0_oe, gp0_oe);
        check_bit("sns_gp1_oe_o", sns_gp1_oe, gp1_oe);
        if (gp0_oe)
            check_bit("sns_gp0_tdi_o", sns_gp0_tdi, m_pgmen ? m_tdi : mode_level(m_gp0, aro));
        if (gp1_oe)
            check_bit("sns_gp1_o", sns_gp1, mode_level(m_gp1, aro));
    endtask

    task automatic test_reset();
        int waited;
        check_bit("sns_mrst_o after reset", sns_mrst, 1'b0);
        check_bit("prsts_o after reset", prsts, 1'b1);
        check_bit("sns_gp0_oe_o after reset", sns_gp0_oe, 1'b0);
        check_bit("sns_gp1_oe_o after reset", sns_gp1_oe, 1'b0);
        check_pins();
        write_reg(`SENSIO_CTRL, 32'h0000_0003); // release sensor mrst
        waited = 0;
        while (prsts && waited < 5) begin
            @(negedge pclk);
            waited++;
        end
        check_bit("prsts_o after mrst release", prsts, 1'b0);
        write_reg(`SENSIO_CTRL, 32'h0000_00c0); // pll reset on
        waited = 0;
        while (!prsts && waited < 5) begin
            @(negedge pclk);
            waited++;
        end
        check_bit("prsts_o with pll reset", prsts, 1'b1);
        write_reg(`SENSIO_CTRL, 32'h0000_0080); // pll reset off
        waited = 0;
        while (prsts && waited < 5) begin
            @(negedge pclk);
            waited++;
        end
        check_bit("prsts_o after pll reset", prsts, 1'b0);
    endtask

    task automatic test_set_enable();
        logic [31:0] sel;
        logic [31:0] word;
        for (int i = 0; i < N_RAND_WR; i++) begin
            rand_bits(1, sel);
            rand_bits(32, word);
            write_reg(sel[0] ? `SENSIO_JTAG : `SENSIO_CTRL, word);
            settle();
            check_pins();
        end
    endtask

    task automatic test_gp_modes();
        logic [31:0] word;
        write_reg(`SENSIO_JTAG, 32'h0000_0200); // jtag mode off
        for (int tm = 0; tm < 2; tm++) begin
            for (int mode = 0; mode < 4; mode++) begin
                for (int lvl = 0; lvl < 2; lvl++) begin
                    word = 32'h0;
                    word[`SENS_CTRL_GP0 +: 2] = mode[1:0];
                    word[`SENS_CTRL_GP0 + 2]  = 1'b1;
                    word[`SENS_CTRL_GP1 +: 2] = mode[1:0];
                    word[`SENS_CTRL_GP1 + 2]  = 1'b1;
                    word[`SENS_CTRL_ARO]      = lvl[0]; // differs from ~trig
                    word[`SENS_CTRL_ARO + 1]  = 1'b1;
                    write_reg(`SENSIO_CTRL, word);
                    trigger_mode = tm[0];
                    trig         = lvl[0];
                    settle();
                    check_pins();
                    if (mode == 3)
                        check_bit("sns_gp1_o in trigger mode", sns_gp1, tm[0] ? ~trig : m_aro);
                end
            end
        end
        trigger_mode = 1'b0;
        trig         = 1'b0;
    endtask

    task automatic test_jtag();
        logic [31:0] word;
        write_reg(`SENSIO_CTRL, 32'h0000_4028); // gp0 float, aro and arst low
        for (int v = 0; v < 8; v++) begin
            word = 32'h0;
            word[`SENS_JTAG_PGMEN +: 2] = 2'b11;
            word[`SENS_JTAG_TCK +: 2]   = {1'b1, v[2]};
            word[`SENS_JTAG_TMS +: 2]   = {1'b1, v[1]};
            word[`SENS_JTAG_TDI +: 2]   = {1'b1, v[0]};
            write_reg(`SENSIO_JTAG, word);
            settle();
            check_pins();
            check_bit("sns_gp0_oe_o in jtag mode", sns_gp0_oe, 1'b1);
        end
        write_reg(`SENSIO_JTAG, 32'h0000_0200); // back to sensor pins
        settle();
        check_pins();
    endtask

    task automatic test_ext_clk();
        logic lvl;
        int   run;
        lvl = ext_clk;
        run = 0;
        while (ext_clk == lvl && run < 12) begin
            @(negedge pclk);
            run++;
        end
        check_bit("ext_clk_o toggling", ext_clk, ~lvl);
        for (int k = 0; k < 40; k++) begin // 20 periods
            lvl = ext_clk;
            run = 0;
            while (ext_clk == lvl && run < 12) begin
                @(negedge pclk);
                run++;
            end
            check_int("ext_clk_o run length", run, 5);
        end
    endtask

    // checks the previous cycle, then drives the next hact level
    task automatic skip_cycle(input logic h, input logic masked);
        @(negedge pclk);
        check_bit("hact_o", hact_out, hact_exp);
        hact     = h;
        hact_exp = h && !masked;
    endtask

    task automatic test_line_skip(input int n);
        write_reg(`SENSIO_SKIP, 32'(n));
        settle();
        sof = 1'b1;
        @(negedge pclk);
        sof = 1'b0;
        for (int line = 0; line < 6; line++) begin
            for (int c = 0; c < 12; c++) begin
                skip_cycle(c < 8, line < n); // 8 active, 4 blank
            end
        end
        skip_cycle(1'b0, 1'b0);
    endtask

    initial begin
        #(WATCHDOG_T);
        $display("watchdog expired before the tests completed");
        $display("Errors found");
        $finish;
    end

    initial begin
        int asrt_fails;
        cmd_we       = 1'b0;
        cmd_addr     = '0;
        cmd_data     = '0;
        sof          = 1'b0;
        hact         = 1'b0;
        trigger_mode = 1'b0;
        trig         = 1'b0;
        m_mrst_n     = 1'b0;
        m_arst       = 1'b0;
        m_aro        = 1'b0;
        m_gp0        = GP_FLOAT;
        m_gp1        = GP_FLOAT;
        m_pgmen      = 1'b0;
        m_tck        = 1'b0;
        m_tms        = 1'b0;
        m_tdi        = 1'b0;
        lfsr         = 32'd99099;
        hact_exp     = 1'b0;
        n_checks     = 0;
        n_errors     = 0;
        wait (rst === 1'b1);
        wait (rst === 1'b0);
        test_reset();
        test_set_enable();
        test_gp_modes();
        test_jtag();
        test_ext_clk();
        test_line_skip(0);
        test_line_skip(1);
        test_line_skip(3);
        repeat (2) @(negedge pclk);
        asrt_fails = u_sens_io_top.u_checker.fail_cnt;
        $display("checks: %0d, check errors: %0d, assertion failures: %0d",
                 n_checks, n_errors, asrt_fails);
        if ((n_errors == 0) && (asrt_fails == 0)) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
+incdir+verilog
verilog/sens_io_pkg.sv
verilog/sens_io_regs.sv
verilog/sens_pin_mux.sv
verilog/sens_ext_clk_gen.sv
verilog/sens_line_skip.sv
verilog/sens_io_top.sv
verification/sens_io_clkgen.sv
verification/sens_io_checker.sv
verification/sens_io_tb.sv

/* Makefile */
.PHONY: all lint clean

all: obj_dir/Vsens_io_tb
	./obj_dir/Vsens_io_tb > sim.log 2>&1; status=$$?; cat sim.log; \
	if [ $$status -ne 0 ] || grep -q "Errors found" sim.log; then exit 1; fi

obj_dir/Vsens_io_tb: tb.f verilog/*.sv verilog/*.svh verification/*.sv
	verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module sens_io_tb

lint:
	verilator --lint-only -Wall +incdir+verilog \
		verilog/sens_io_pkg.sv verilog/sens_io_regs.sv verilog/sens_pin_mux.sv \
		verilog/sens_ext_clk_gen.sv verilog/sens_line_skip.sv verilog/sens_io_top.sv \
		--top-module sens_io_top

clean:
	rm -rf obj_dir sim.log
